// File: design/opl3_reg_pkg.sv
`default_nettype none

// shared widths and sizes of the OPL3 register store.
package opl3_reg_pkg;
    localparam int data_w = 8;           // each register holds one byte.
    localparam int depth = 32;           // register slots in one bank.
    localparam int num_banks = 2;        // the two halves of the OPL3 register map.
    localparam int read_delay = 2;       // registered read stages in every bank.

    // one register value.
    typedef logic [data_w-1:0] data_t;

    // slot address inside a bank.
    typedef logic [$clog2(depth)-1:0] slot_t;

    // bank number, one bit for two banks.
    typedef logic [$clog2(num_banks)-1:0] bank_t;

    // host word address, the bank sits above the slot bits.
    typedef logic [$bits(bank_t)+$bits(slot_t)-1:0] wb_adr_t;

    // power-up contents of every register.
    localparam data_t default_value = '0;
endpackage

`default_nettype wire

// File: design/pipeline_sr.sv
`timescale 1ns/100ps
`default_nettype none

// delays a small value by up to ENDING_CYCLE clocks.
// every stage is visible so the caller picks the tap for its own latency.
module pipeline_sr #(
    parameter int DATA_WIDTH = 1,
    parameter int ENDING_CYCLE = 1
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [DATA_WIDTH-1:0]                 in,
    output logic [ENDING_CYCLE:1][DATA_WIDTH-1:0] out  // out[n] is in delayed by n clocks.
);
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out <= '0;                                  // empty pipeline after reset.
        end else begin
            out[1] <= in;                               // first stage samples the input.
            for (int k = 2; k <= ENDING_CYCLE; k++) begin
                out[k] <= out[k-1];                     // later stages shift along.
            end
        end
    end
endmodule

`default_nettype wire

// File: design/mem_simple_dual_port.sv
`timescale 1ns/100ps
`default_nettype none

// one register bank with a write port a and a read port b on one clock.
module mem_simple_dual_port #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH = 32,
    parameter int OUTPUT_DELAY = 2,     // 0, 1 or 2 registered read stages.
    parameter int DEFAULT_VALUE = 0
) (
    input  logic                clk,
    input  logic                wea,
    input  logic                reb,    // only matters with a registered read.
    input  opl3_reg_pkg::slot_t addra,
    input  opl3_reg_pkg::slot_t addrb,
    input  opl3_reg_pkg::data_t dia,
    output opl3_reg_pkg::data_t dob
);
    logic [DATA_WIDTH-1:0] ram [DEPTH];

    // the array powers up with the default register value.
    initial begin
        for (int k = 0; k < DEPTH; k++) begin
            ram[k] = DATA_WIDTH'(DEFAULT_VALUE);
        end
    end

    always_ff @(posedge clk) begin
        if (wea) ram[addra] <= dia;     // port a only writes.
    end

    // the read below sees the old word when both ports hit one slot.
    if (OUTPUT_DELAY == 0) begin : g_comb_read
        always_comb dob = ram[addrb];   // asynchronous read, no latency.
    end else if (OUTPUT_DELAY == 1) begin : g_one_stage
        always_ff @(posedge clk) begin
            if (reb) dob <= ram[addrb]; // holds the last word between reads.
        end
    end else begin : g_two_stage
        opl3_reg_pkg::data_t rd_q;      // first read stage.
        logic                rd_q_vld;  // first stage holds a fresh word.

        always_ff @(posedge clk) begin
            rd_q_vld <= reb;
            if (reb) rd_q <= ram[addrb];
            if (rd_q_vld) dob <= rd_q;  // the output stage follows a valid first stage.
        end
    end
endmodule

`default_nettype wire

// File: design/mem_multi_bank.sv
`timescale 1ns/100ps
`default_nettype none

// several dual-port banks behind one write port and one read port.
// the bank number picks which array writes or reads.
module mem_multi_bank #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH = 32,
    parameter int OUTPUT_DELAY = 2,     // read latency of every bank.
    parameter int DEFAULT_VALUE = 0,
    parameter int NUM_BANKS = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wea,
    input  logic                reb,
    input  opl3_reg_pkg::bank_t banka,
    input  opl3_reg_pkg::slot_t addra,
    input  opl3_reg_pkg::bank_t bankb,
    input  opl3_reg_pkg::slot_t addrb,
    input  opl3_reg_pkg::data_t dia,
    output opl3_reg_pkg::data_t dob
);
    localparam int bank_w = $bits(opl3_reg_pkg::bank_t);

    logic [NUM_BANKS-1:0]  wea_bank;                // one write enable per bank.
    logic [NUM_BANKS-1:0]  reb_bank;                // one read enable per bank.
    logic [DATA_WIDTH-1:0] dob_bank [NUM_BANKS];    // raw output of each bank.

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        // only the addressed bank sees its enable.
        assign wea_bank[i] = wea && (banka == bank_w'(i));
        assign reb_bank[i] = reb && (bankb == bank_w'(i));

        mem_simple_dual_port #(
            .DATA_WIDTH   (DATA_WIDTH),
            .DEPTH        (DEPTH),
            .OUTPUT_DELAY (OUTPUT_DELAY),
            .DEFAULT_VALUE(DEFAULT_VALUE)
        ) u_bank (
            .clk  (clk),
            .wea  (wea_bank[i]),
            .reb  (reb_bank[i]),
            .addra(addra),          // address and data are shared by all banks.
            .addrb(addrb),
            .dia  (dia),
            .dob  (dob_bank[i])
        );
    end

    if (OUTPUT_DELAY == 0) begin : g_sel_now
        assign dob = dob_bank[bankb];   // data comes back in the same cycle.
    end else begin : g_sel_late
        logic [OUTPUT_DELAY:1][bank_w-1:0] bankb_p; // bank number of reads in flight.

        // the bank number travels with the read so back-to-back reads from
        // different banks each select their own array.
        pipeline_sr #(
            .DATA_WIDTH  (bank_w),
            .ENDING_CYCLE(OUTPUT_DELAY)
        ) u_bankb_sr (
            .clk  (clk),
            .rst_n(rst_n),
            .in   (bankb),
            .out  (bankb_p)
        );

        assign dob = dob_bank[bankb_p[OUTPUT_DELAY]];
    end
endmodule

`default_nettype wire

// File: design/wb_reg_port.sv
`timescale 1ns/100ps
`default_nettype none

// Wishbone classic slave that turns host cycles into register writes.
// every request gets exactly one ack cycle, one clock after it is seen.
module wb_reg_port (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  opl3_reg_pkg::wb_adr_t wb_adr,
    input  opl3_reg_pkg::data_t   wb_dat_w,
    output logic                  wb_ack,
    output opl3_reg_pkg::data_t   wb_dat_r,
    output logic                  wr_en,    // one-cycle write pulse, aligned with ack.
    output opl3_reg_pkg::bank_t   wr_bank,
    output opl3_reg_pkg::slot_t   wr_slot,
    output opl3_reg_pkg::data_t   wr_data
);
    localparam int slot_w = $bits(opl3_reg_pkg::slot_t);

    typedef enum logic {
        st_idle,                            // waiting for a request.
        st_ack                              // acknowledging the captured request.
    } state_t;

    state_t                state;
    logic                  req_take;        // a request is accepted this cycle.
    logic                  we_q;            // captured cycle was a write.
    opl3_reg_pkg::wb_adr_t adr_q;
    opl3_reg_pkg::data_t   dat_q;

    // no new request is taken during the ack cycle.
    assign req_take = (state == st_idle) && wb_cyc && wb_stb;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            we_q  <= 1'b0;
        end else begin
            case (state)
                st_idle: if (req_take) begin
                    state <= st_ack;
                    we_q  <= wb_we;
                end
                st_ack:  state <= st_idle;  // ack lasts one cycle only.
                default: state <= st_idle;
            endcase
        end
    end

    // address and write data are captured with the request.
    always_ff @(posedge clk) begin
        if (req_take) begin
            adr_q <= wb_adr;
            dat_q <= wb_dat_w;
        end
    end

    assign wb_ack   = (state == st_ack);
    assign wr_en    = wb_ack && we_q;       // the memory updates on the edge after ack.
    assign wr_bank  = adr_q[slot_w +: $bits(opl3_reg_pkg::bank_t)];  // top address bit.
    assign wr_slot  = adr_q[slot_w-1:0];
    assign wr_data  = dat_q;
    assign wb_dat_r = '0;                   // the read port belongs to the scanner.
endmodule

`default_nettype wire

// File: design/operator_scan.sv
`timescale 1ns/100ps
`default_nettype none

// free-running sweep over every slot of every bank.
// each returning read is tagged with the bank and slot it came from.
module operator_scan (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run,        // scanning proceeds while high.
    output logic                rd_en,
    output opl3_reg_pkg::bank_t rd_bank,
    output opl3_reg_pkg::slot_t rd_slot,
    input  opl3_reg_pkg::data_t rd_data,
    output logic                op_valid,
    output opl3_reg_pkg::bank_t op_bank,
    output opl3_reg_pkg::slot_t op_slot,
    output opl3_reg_pkg::data_t op_data
);
    localparam int dly = opl3_reg_pkg::read_delay;
    localparam int tag_w = 1 + $bits(opl3_reg_pkg::bank_t) + $bits(opl3_reg_pkg::slot_t);

    opl3_reg_pkg::bank_t          scan_bank;    // bank of the next read.
    opl3_reg_pkg::slot_t          scan_slot;    // slot of the next read.
    logic [dly:1][tag_w-1:0]      tag_p;        // valid flag and tag of reads in flight.

    // the counter moves one slot per issued read and carries into the bank.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_bank <= '0;
            scan_slot <= '0;
        end else if (run) begin
            if (scan_slot == opl3_reg_pkg::slot_t'(opl3_reg_pkg::depth - 1)) begin
                scan_slot <= '0;
                if (scan_bank == opl3_reg_pkg::bank_t'(opl3_reg_pkg::num_banks - 1))
                    scan_bank <= '0;                        // wrap after the last bank.
                else
                    scan_bank <= scan_bank + 1'b1;
            end else begin
                scan_slot <= scan_slot + 1'b1;
            end
        end
    end

    // a read goes out in every cycle that run is high, so it stops at once.
    assign rd_en   = run;
    assign rd_bank = scan_bank;
    assign rd_slot = scan_slot;

    // the tag waits as long as the memory does.
    pipeline_sr #(
        .DATA_WIDTH  (tag_w),
        .ENDING_CYCLE(dly)
    ) u_tag_sr (
        .clk  (clk),
        .rst_n(rst_n),
        .in   ({rd_en, rd_bank, rd_slot}),
        .out  (tag_p)
    );

    assign {op_valid, op_bank, op_slot} = tag_p[dly];
    assign op_data = rd_data;               // lines up with the delayed tag.
endmodule

`default_nettype wire

// File: design/opl3_reg_top.sv
`timescale 1ns/100ps
`default_nettype none

// register store of the FM core: host port, two-bank memory and scanner.
module opl3_reg_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  opl3_reg_pkg::wb_adr_t wb_adr,
    input  opl3_reg_pkg::data_t   wb_dat_w,
    output logic                  wb_ack,
    output opl3_reg_pkg::data_t   wb_dat_r,
    input  logic                  run,
    output logic                  op_valid,
    output opl3_reg_pkg::bank_t   op_bank,
    output opl3_reg_pkg::slot_t   op_slot,
    output opl3_reg_pkg::data_t   op_data
);
    logic                wr_en;     // host write path.
    opl3_reg_pkg::bank_t wr_bank;
    opl3_reg_pkg::slot_t wr_slot;
    opl3_reg_pkg::data_t wr_data;
    logic                rd_en;     // scanner read path.
    opl3_reg_pkg::bank_t rd_bank;
    opl3_reg_pkg::slot_t rd_slot;
    opl3_reg_pkg::data_t rd_data;

    wb_reg_port u_wb_reg_port (
        .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
        .wr_en(wr_en), .wr_bank(wr_bank), .wr_slot(wr_slot), .wr_data(wr_data)
    );

    mem_multi_bank #(
        .DATA_WIDTH(opl3_reg_pkg::data_w), .DEPTH(opl3_reg_pkg::depth),
        .OUTPUT_DELAY(opl3_reg_pkg::read_delay),
        .DEFAULT_VALUE(int'(opl3_reg_pkg::default_value)),
        .NUM_BANKS(opl3_reg_pkg::num_banks)
    ) u_regs (
        .clk(clk), .rst_n(rst_n), .wea(wr_en), .reb(rd_en), .banka(wr_bank),
        .addra(wr_slot), .bankb(rd_bank), .addrb(rd_slot), .dia(wr_data), .dob(rd_data)
    );

    operator_scan u_operator_scan (
        .clk(clk), .rst_n(rst_n), .run(run), .rd_en(rd_en), .rd_bank(rd_bank),
        .rd_slot(rd_slot), .rd_data(rd_data), .op_valid(op_valid), .op_bank(op_bank),
        .op_slot(op_slot), .op_data(op_data)
    );
endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

// free-running testbench clock.
module tb_clock_gen #(
    parameter int PERIOD_NS = 10
) (
    output logic clk
);
    initial clk = 1'b0;                        // starts low so the first edge is a rising one.

    always #(PERIOD_NS / 2) clk = ~clk;        // equal high and low phases.
endmodule

`default_nettype wire

// File: sim/tb_checker.sv
`timescale 1ns/100ps
`default_nettype none

// watches the register store, keeps a model of every register and checks the stream.
module tb_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [127:0]          test_name,     // short ascii label of the running test.
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  opl3_reg_pkg::wb_adr_t wb_adr,
    input  opl3_reg_pkg::data_t   wb_dat_w,
    input  logic                  wb_ack,
    input  opl3_reg_pkg::data_t   wb_dat_r,
    input  logic                  run,
    input  logic                  op_valid,
    input  opl3_reg_pkg::bank_t   op_bank,
    input  opl3_reg_pkg::slot_t   op_slot,
    input  opl3_reg_pkg::data_t   op_data,
    output int                    beats,         // stream beats seen so far.
    output int                    issues,        // cycles with run high, one read each.
    output int                    errors
);
    localparam int slots = opl3_reg_pkg::num_banks * opl3_reg_pkg::depth;

    opl3_reg_pkg::data_t   model [slots] = '{default: opl3_reg_pkg::default_value};
    int                    stamp [slots] = '{default: -100};  // cycle of the last write.
    opl3_reg_pkg::wb_adr_t exp_pos = '0;         // bank and slot the scan should report next.
    opl3_reg_pkg::wb_adr_t pos;
    logic                  ack_prev = 1'b0;
    int                    cycle = 0;
    int                    beat_cnt = 0;
    int                    issue_cnt = 0;
    int                    err_cnt = 0;

    // value a register should hold after the host writes seen so far.
    function automatic opl3_reg_pkg::data_t expected_value(input opl3_reg_pkg::bank_t bank,
                                                           input opl3_reg_pkg::slot_t slot);
        return model[{bank, slot}];
    endfunction

    always @(posedge clk) begin
        if (rst_n) begin
            cycle++;
            if (run) issue_cnt++;
            if (op_valid) begin
                pos = {op_bank, op_slot};
                beat_cnt++;
                if (pos != exp_pos) begin
                    $display("Fail %0s: tag expected %h, actual %h", test_name, exp_pos, pos);
                    err_cnt++;
                end
                // a write acked in the last three cycles may or may not be in this beat.
                if (cycle - stamp[pos] > 3 && op_data != expected_value(op_bank, op_slot)) begin
                    $display("Fail %0s: data at %h expected %h, actual %h", test_name, pos,
                             expected_value(op_bank, op_slot), op_data);
                    err_cnt++;
                end
                exp_pos = exp_pos + 1'b1;        // slot first, then the carry into the bank.
            end
            if (wb_ack && !(wb_cyc && wb_stb)) begin
                $display("ack came while the host had no request pending");
                err_cnt++;
            end
            if (wb_ack && ack_prev) begin
                $display("ack stayed high for more than one cycle");
                err_cnt++;
            end
            if (wb_ack && wb_we) begin
                model[wb_adr] = wb_dat_w;        // the memory takes the write on this edge.
                stamp[wb_adr] = cycle;
            end else if (wb_ack && wb_dat_r != '0) begin
                $display("Fail %0s: read data expected %h, actual %h", test_name,
                         opl3_reg_pkg::data_t'(0), wb_dat_r);
                err_cnt++;
            end
            ack_prev = wb_ack;
        end
        beats  <= beat_cnt;                      // counters settle after the edge.
        issues <= issue_cnt;
        errors <= err_cnt;
    end
endmodule

`default_nettype wire

// File: sim/tb_opl3_reg.sv
`timescale 1ns/100ps
`default_nettype none

// testbench top for the OPL3 register store.
module tb_opl3_reg;
    localparam int ack_limit = 16;              // cycles allowed for one ack.
    localparam int drain_limit = 16;            // cycles allowed for reads in flight.

    logic                  clk;
    logic                  rst_n;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    opl3_reg_pkg::wb_adr_t wb_adr;
    opl3_reg_pkg::data_t   wb_dat_w;
    logic                  wb_ack;
    opl3_reg_pkg::data_t   wb_dat_r;
    logic                  run;
    logic                  op_valid;
    opl3_reg_pkg::bank_t   op_bank;
    opl3_reg_pkg::slot_t   op_slot;
    opl3_reg_pkg::data_t   op_data;
    logic [127:0]          test_name;
    int                    beats;
    int                    issues;
    int                    errors;
    integer                seed = 30;
    int                    n_pass = 0;
    int                    n_fail = 0;
    int                    err_mark;
    logic                  timed_out;

    tb_clock_gen u_clock_gen (.clk(clk));
    opl3_reg_top u_dut (.*);
    tb_checker   u_checker (.*);

    task automatic start_test(input logic [127:0] name);
        test_name = name;
        err_mark  = errors;                     // errors before the test starts.
        timed_out = 1'b0;
    endtask

    task automatic finish_test(input int num);
        if (errors == err_mark && !timed_out) begin
            n_pass++;
            $display("test %0d %0s: pass", num, test_name);
        end else begin
            n_fail++;
            $display("test %0d %0s: failed", num, test_name);
        end
    endtask

    // one Wishbone classic cycle, held until ack or until the limit runs out.
    task automatic wb_access(input logic we, input opl3_reg_pkg::wb_adr_t adr,
                             input opl3_reg_pkg::data_t dat);
        int waited;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!wb_ack && waited < ack_limit);
        if (!wb_ack) begin
            timed_out = 1'b1;
            $display("no ack from the host port within %0d cycles", ack_limit);
        end
        wb_cyc <= 1'b0;                         // stb drops in the cycle after ack.
        wb_stb <= 1'b0;
        @(posedge clk);
    endtask

    // waits until every issued read has come back on the stream.
    task automatic drain();
        int goal;
        int waited;
        @(posedge clk);
        goal = issues;                          // now includes the last issued read.
        waited = 0;
        while (beats < goal && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        if (beats < goal) begin
            timed_out = 1'b1;
            $display("only %0d of %0d stream beats arrived", beats, goal);
        end
        // a beat without an issued read would show up within the read latency.
        repeat (opl3_reg_pkg::read_delay + 1) @(posedge clk);
        if (beats > goal) begin
            timed_out = 1'b1;
            $display("%0d stream beats arrived for only %0d issued reads", beats, goal);
        end
    endtask

    task automatic sweep(input int reads);
        run <= 1'b1;
        repeat (reads) @(posedge clk);          // one read per clock while run is high.
        run <= 1'b0;
        drain();
    endtask

    initial begin
        int on_len;
        int off_len;
        opl3_reg_pkg::slot_t slot;
        rst_n     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        run       = 1'b0;
        test_name = "reset";
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        start_test("defaults");
        sweep(64);
        finish_test(1);

        start_test("bank split");
        for (int k = 0; k < 4; k++) begin
            slot = opl3_reg_pkg::slot_t'($random(seed));
            wb_access(1'b1, {opl3_reg_pkg::bank_t'(0), slot}, opl3_reg_pkg::data_t'(8'h10 + k));
            wb_access(1'b1, {opl3_reg_pkg::bank_t'(1), slot}, opl3_reg_pkg::data_t'(8'hc0 + k));
        end
        sweep(64);
        finish_test(2);

        start_test("random fill");
        repeat (64) begin
            wb_access(1'b1, opl3_reg_pkg::wb_adr_t'($random(seed)),
                      opl3_reg_pkg::data_t'($random(seed)));
        end
        sweep(128);                             // two sweeps cross the bank edge twice.
        finish_test(3);

        start_test("pause resume");
        repeat (12) begin
            on_len  = 1 + ($unsigned($random(seed)) % 9);
            off_len = 1 + ($unsigned($random(seed)) % 4);
            run <= 1'b1;
            repeat (on_len) @(posedge clk);
            run <= 1'b0;                        // reads in flight still come back.
            repeat (off_len) @(posedge clk);
        end
        drain();
        finish_test(4);

        start_test("live writes");
        run <= 1'b1;
        repeat (16) begin
            wb_access(1'b1, opl3_reg_pkg::wb_adr_t'($random(seed)),
                      opl3_reg_pkg::data_t'($random(seed)));
        end
        repeat (70) @(posedge clk);             // a full sweep after the last write.
        run <= 1'b0;
        drain();
        finish_test(5);

        start_test("host protocol");
        for (int k = 0; k < 4; k++) begin
            wb_access(1'b1, opl3_reg_pkg::wb_adr_t'($random(seed)),
                      opl3_reg_pkg::data_t'($random(seed)));
            wb_access(1'b0, opl3_reg_pkg::wb_adr_t'($random(seed)), 8'hff);
        end
        finish_test(6);

        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

// File: files.f
design/opl3_reg_pkg.sv
design/pipeline_sr.sv
design/mem_simple_dual_port.sv
design/mem_multi_bank.sv
design/wb_reg_port.sv
design/operator_scan.sv
design/opl3_reg_top.sv
sim/tb_clock_gen.sv
sim/tb_checker.sv
sim/tb_opl3_reg.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing -j 0 --top-module tb_opl3_reg -Mdir "$build_dir" -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vtb_opl3_reg" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$log"; then
    exit 0
fi
exit 1
